//--- hw/au_isa_pkg.sv
// Opcodes 06h to 0Fh retire bad_result, and the immediate form only reaches opcodes 00h to 0Fh
package au_isa_pkg;

  // Host word, bit 28 set marks an immediate prefix
  typedef logic [28:0] instr_t;

  // Operation word
  // [14] immediate form, [13:9] opcode, [8:6] reg A, [5:3] reg B or imm, [2:0] reg C
  typedef logic [14:0] op_t;

  typedef logic [4:0] opcode_t;

  // Prefix payload, becomes bits 31..4 of a full immediate
  typedef logic [27:0] imm_t;

  // Register or full-immediate operations
  localparam opcode_t opc_or   = 5'h00;
  localparam opcode_t opc_xor  = 5'h01;
  localparam opcode_t opc_cmp  = 5'h02;
  localparam opcode_t opc_add  = 5'h03;
  localparam opcode_t opc_sub  = 5'h04;
  localparam opcode_t opc_and  = 5'h05;

  // The 3-bit B field acts as bit index, shift amount or small immediate
  localparam opcode_t opc_bset = 5'h10;
  localparam opcode_t opc_bclr = 5'h11;
  localparam opcode_t opc_subi = 5'h12;
  localparam opcode_t opc_addi = 5'h13;
  localparam opcode_t opc_shl  = 5'h14;
  localparam opcode_t opc_shr  = 5'h15;
  localparam opcode_t opc_sra  = 5'h16;
  localparam opcode_t opc_sext = 5'h17;

  // Retired by every unused opcode
  localparam logic [31:0] bad_result = 32'hFFFF_FBAD;

endpackage

//--- hw/au_core_pkg.sv
// Thread count is tied to the 2-bit slice counter, and flag bits 7..4 are reserved as zero
package au_core_pkg;

  localparam int num_threads = 4;

  // Hardware thread, also the slice number that owns a slot
  typedef logic [1:0] thread_t;

  // Register select within one thread
  typedef logic [2:0] reg_sel_t;

  typedef logic [31:0] word_t;

  // Flag word
  // bit 0 zero, bit 1 negative, bit 2 signed overflow, bit 3 carry or borrow
  typedef logic [7:0] flags_t;

  // Host handshake states
  typedef enum logic [1:0]
  {
    idle,
    wait_slot,
    acked
  } slice_state_t;

endpackage

//--- hw/au_issue.sv
// One host request at a time, and a held prefix stays with its thread until that thread sends another
`timescale 1ns/10ps

module au_issue
(
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 instr_req,
  input  au_core_pkg::thread_t instr_thread,
  input  au_isa_pkg::instr_t   instr,
  output logic                 instr_ack,
  output logic                 op_vld,
  output au_isa_pkg::op_t      op,
  output au_core_pkg::thread_t slice,
  output au_isa_pkg::imm_t     imm_hi
);

  au_core_pkg::thread_t      slice_cnt;
  au_core_pkg::slice_state_t state;
  au_isa_pkg::imm_t          hold_q [au_core_pkg::num_threads];
  logic                      is_prefix;
  logic                      accept;

  // Free-running slot counter, one slot per thread every fourth cycle
  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
      slice_cnt <= '0;
    else
      slice_cnt <= slice_cnt + 2'd1;
  end

  assign is_prefix = instr[28];

  // Take the word only in the owning thread's slot
  assign accept = instr_req && (instr_thread == slice_cnt) && (state != au_core_pkg::acked);

  // Four-phase handshake
  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
      state <= au_core_pkg::idle;
    else
    begin
      case (state)
        au_core_pkg::idle:
        begin
          if (accept)
            state <= au_core_pkg::acked;
          else if (instr_req)
            state <= au_core_pkg::wait_slot;
        end
        au_core_pkg::wait_slot:
        begin
          if (accept)
            state <= au_core_pkg::acked;
          else if (!instr_req)
            state <= au_core_pkg::idle;
        end
        default:
        begin
          // Ack held until the host lets go of req
          if (!instr_req)
            state <= au_core_pkg::idle;
        end
      endcase
    end
  end

  assign instr_ack = (state == au_core_pkg::acked);

  // Single-cycle issue strobe, same cycle as the ack rises
  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
      op_vld <= 1'b0;
    else
      op_vld <= accept && !is_prefix;
  end

  always_ff @(posedge CLK)
  begin
    if (accept && !is_prefix)
    begin
      op    <= instr[14:0];
      slice <= instr_thread;
    end
  end

  // Per-thread prefix hold registers
  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
    begin
      for (int t = 0; t < au_core_pkg::num_threads; t++)
        hold_q[t] <= '0;
    end
    else if (accept && is_prefix)
      hold_q[instr_thread] <= instr[27:0];
  end

  assign imm_hi = hold_q[slice];

endmodule

//--- hw/au_regfile.sv
// Reads are combinational, and a read of the register being written returns the old value
`timescale 1ns/10ps

module au_regfile
(
  input  logic                  CLK,
  input  logic                  RST,
  input  au_core_pkg::thread_t  rd_thread,
  input  au_core_pkg::reg_sel_t ra_sel,
  input  au_core_pkg::reg_sel_t rb_sel,
  output au_core_pkg::word_t    ra,
  output au_core_pkg::word_t    rb,
  input  logic                  wr_en,
  input  au_core_pkg::thread_t  wr_thread,
  input  au_core_pkg::reg_sel_t wr_sel,
  input  au_core_pkg::word_t    wr_data
);

  // Eight registers per thread
  au_core_pkg::word_t regs [au_core_pkg::num_threads][2 ** $bits(au_core_pkg::reg_sel_t)];

  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
    begin
      foreach (regs[t, r])
        regs[t][r] <= '0;
    end
    else if (wr_en)
      regs[wr_thread][wr_sel] <= wr_data;
  end

  // Both read ports serve the thread that owns the current issue
  assign ra = regs[rd_thread][ra_sel];
  assign rb = regs[rd_thread][rb_sel];

endmodule

//--- hw/au_exec.sv
// Fixed two-stage latency with no stall, and results are not forwarded between ops of one thread
`timescale 1ns/10ps

module au_exec
(
  input  logic                  CLK,
  input  logic                  RST,
  input  logic                  op_vld,
  input  au_isa_pkg::op_t       op,
  input  au_core_pkg::thread_t  slice,
  input  au_isa_pkg::imm_t      imm_hi,
  input  au_core_pkg::word_t    ra,
  input  au_core_pkg::word_t    rb,
  output logic                  wb_vld,
  output au_core_pkg::thread_t  wb_thread,
  output au_core_pkg::reg_sel_t wb_sel,
  output au_core_pkg::word_t    wb_data,
  output logic                  retire_vld,
  output au_core_pkg::flags_t   retire_flags
);

  logic                  imm_form;
  au_isa_pkg::opcode_t   opc;
  au_core_pkg::word_t    imm_word;

  logic                  s1_vld;
  au_core_pkg::word_t    s1_a;
  au_core_pkg::word_t    s1_b;
  au_isa_pkg::opcode_t   s1_opc;
  logic [2:0]            s1_fa;
  logic [2:0]            s1_fb;
  au_core_pkg::reg_sel_t s1_sel;
  au_core_pkg::thread_t  s1_thread;

  logic                  is_sub;
  logic                  is_arith;
  au_core_pkg::word_t    add_b;
  logic [32:0]           sum;
  logic                  ovf;
  au_core_pkg::word_t    bit_mask;
  au_core_pkg::word_t    result;

  logic                  s2_vld;
  logic                  s2_wr;
  au_core_pkg::thread_t  s2_thread;
  au_core_pkg::reg_sel_t s2_sel;
  au_core_pkg::word_t    s2_result;
  logic                  s2_carry;
  logic                  s2_ovf;

  // Decode, immediate form masks the opcode down to 00h..0Fh
  assign imm_form = op[14];
  assign opc      = op[13:9] & (imm_form ? 5'h0F : 5'h1F);
  assign imm_word = {imm_hi, op[13], op[5:3]};

  // Stage 1 operand capture
  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
      s1_vld <= 1'b0;
    else
      s1_vld <= op_vld;
  end

  always_ff @(posedge CLK)
  begin
    if (op_vld)
    begin
      s1_a      <= ra;
      s1_b      <= imm_form ? imm_word : rb;
      s1_opc    <= opc;
      s1_fa     <= op[8:6];
      s1_fb     <= op[5:3];
      s1_sel    <= op[2:0];
      s1_thread <= slice;
    end
  end

  // Adder shared by add, sub, compare and their small-immediate forms
  always_comb
  begin
    is_sub   = (s1_opc == au_isa_pkg::opc_sub) || (s1_opc == au_isa_pkg::opc_cmp) ||
               (s1_opc == au_isa_pkg::opc_subi);
    is_arith = is_sub || (s1_opc == au_isa_pkg::opc_add) || (s1_opc == au_isa_pkg::opc_addi);
    // 10h and above take the raw 3-bit field
    add_b    = s1_opc[4] ? {29'd0, s1_fb} : s1_b;
    if (is_sub)
      sum = {1'b0, s1_a} - {1'b0, add_b};
    else
      sum = {1'b0, s1_a} + {1'b0, add_b};
    if (is_sub)
      ovf = (s1_a[31] != add_b[31]) && (sum[31] != s1_a[31]);
    else
      ovf = (s1_a[31] == add_b[31]) && (sum[31] != s1_a[31]);
    bit_mask = 32'd1 << s1_fb;
  end

  always_comb
  begin
    if (s1_opc[4:3] == 2'b11)
      // Load constant, 9 bits taken from op[11:3]
      result = {{23{s1_opc[2]}}, s1_opc[2:0], s1_fa, s1_fb};
    else
    begin
      case (s1_opc)
        au_isa_pkg::opc_or:   result = s1_a | s1_b;
        au_isa_pkg::opc_xor:  result = s1_a ^ s1_b;
        au_isa_pkg::opc_cmp,
        au_isa_pkg::opc_add,
        au_isa_pkg::opc_sub,
        au_isa_pkg::opc_subi,
        au_isa_pkg::opc_addi: result = sum[31:0];
        au_isa_pkg::opc_and:  result = s1_a & s1_b;
        au_isa_pkg::opc_bset: result = s1_a | bit_mask;
        au_isa_pkg::opc_bclr: result = s1_a & ~bit_mask;
        au_isa_pkg::opc_shl:  result = s1_a << s1_fb;
        au_isa_pkg::opc_shr:  result = s1_a >> s1_fb;
        au_isa_pkg::opc_sra:  result = $signed(s1_a) >>> s1_fb;
        au_isa_pkg::opc_sext:
        begin
          // Source width picked by the low two field bits
          case (s1_fb[1:0])
            2'd0:    result = {32{s1_a[0]}};
            2'd1:    result = {{24{s1_a[7]}}, s1_a[7:0]};
            2'd2:    result = {{16{s1_a[15]}}, s1_a[15:0]};
            default: result = {{8{s1_a[23]}}, s1_a[23:0]};
          endcase
        end
        default:              result = au_isa_pkg::bad_result;
      endcase
    end
  end

  // Stage 2 result register
  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
      s2_vld <= 1'b0;
    else
      s2_vld <= s1_vld;
  end

  always_ff @(posedge CLK)
  begin
    if (s1_vld)
    begin
      s2_wr     <= (s1_opc != au_isa_pkg::opc_cmp);
      s2_thread <= s1_thread;
      s2_sel    <= s1_sel;
      s2_result <= result;
      s2_carry  <= is_arith && sum[32];
      s2_ovf    <= is_arith && ovf;
    end
  end

  assign retire_vld = s2_vld;
  // Compare retires without a register write
  assign wb_vld     = s2_vld && s2_wr;
  assign wb_thread  = s2_thread;
  assign wb_sel     = s2_sel;
  assign wb_data    = s2_result;

  // Reserved nibble reads as zero
  assign retire_flags = {4'h0, s2_carry, s2_ovf, s2_result[31], (s2_result == '0)};

endmodule

//--- hw/au_top.sv
// No output back-pressure, so wb and retire outputs must be taken in the cycle they are valid
`timescale 1ns/10ps

module au_top
(
  input  logic                  CLK,
  input  logic                  RST,
  input  logic                  instr_req,
  input  au_core_pkg::thread_t  instr_thread,
  input  au_isa_pkg::instr_t    instr,
  output logic                  instr_ack,
  output logic                  wb_vld,
  output au_core_pkg::thread_t  wb_thread,
  output au_core_pkg::reg_sel_t wb_sel,
  output au_core_pkg::word_t    wb_data,
  output logic                  retire_vld,
  output au_core_pkg::flags_t   retire_flags
);

  logic                 op_vld;
  au_isa_pkg::op_t      op;
  au_core_pkg::thread_t slice;
  au_isa_pkg::imm_t     imm_hi;
  au_core_pkg::word_t   ra;
  au_core_pkg::word_t   rb;

  au_issue u_issue
  (
    .CLK          (CLK),
    .RST          (RST),
    .instr_req    (instr_req),
    .instr_thread (instr_thread),
    .instr        (instr),
    .instr_ack    (instr_ack),
    .op_vld       (op_vld),
    .op           (op),
    .slice        (slice),
    .imm_hi       (imm_hi)
  );

  // Register selects come straight from the issued op word
  au_regfile u_regfile
  (
    .CLK       (CLK),
    .RST       (RST),
    .rd_thread (slice),
    .ra_sel    (op[8:6]),
    .rb_sel    (op[5:3]),
    .ra        (ra),
    .rb        (rb),
    .wr_en     (wb_vld),
    .wr_thread (wb_thread),
    .wr_sel    (wb_sel),
    .wr_data   (wb_data)
  );

  au_exec u_exec
  (
    .CLK          (CLK),
    .RST          (RST),
    .op_vld       (op_vld),
    .op           (op),
    .slice        (slice),
    .imm_hi       (imm_hi),
    .ra           (ra),
    .rb           (rb),
    .wb_vld       (wb_vld),
    .wb_thread    (wb_thread),
    .wb_sel       (wb_sel),
    .wb_data      (wb_data),
    .retire_vld   (retire_vld),
    .retire_flags (retire_flags)
  );

endmodule

//--- tests/au_chk.sv
// Assertions are off while RST is high and watch the issue strobe and op word inside au_top
`timescale 1ns/10ps

module au_chk
(
  input logic            CLK,
  input logic            RST,
  input logic            instr_req,
  input logic            instr_ack,
  input logic            op_vld,
  input au_isa_pkg::op_t op,
  input logic            wb_vld,
  input logic            retire_vld
);

  logic is_cmp;

  // Immediate form only reaches opcodes 00h to 0Fh
  assign is_cmp = ((op[13:9] & (op[14] ? 5'h0F : 5'h1F)) == au_isa_pkg::opc_cmp);

  ack_needs_req: assert property (@(posedge CLK) disable iff (RST)
    $rose(instr_ack) |-> instr_req)
    else $error("instr_ack rose while instr_req was low");

  // Fixed two-stage pipeline
  retire_latency: assert property (@(posedge CLK) disable iff (RST)
    retire_vld == $past(op_vld, 2))
    else $error("retire_vld does not follow op_vld by two cycles");

  cmp_no_write: assert property (@(posedge CLK) disable iff (RST)
    $past(op_vld && is_cmp, 2) |-> (retire_vld && !wb_vld))
    else $error("compare retired with a register write");

endmodule

//--- tests/au_tb.sv
// Must run from the project root to find tests/au_testdata.txt and remaps file threads by a seeded shuffle
`timescale 1ns/10ps

module au_tb;

  localparam int timeout_cycles = 16;

  logic                  CLK;
  logic                  RST;
  logic                  instr_req;
  au_core_pkg::thread_t  instr_thread;
  au_isa_pkg::instr_t    instr;
  logic                  instr_ack;
  logic                  wb_vld;
  au_core_pkg::thread_t  wb_thread;
  au_core_pkg::reg_sel_t wb_sel;
  au_core_pkg::word_t    wb_data;
  logic                  retire_vld;
  au_core_pkg::flags_t   retire_flags;

  int                    errors;
  int                    timeouts;
  int                    checks;
  integer                seed;
  au_core_pkg::thread_t  thread_map [au_core_pkg::num_threads];

  au_top uut
  (
    .CLK          (CLK),
    .RST          (RST),
    .instr_req    (instr_req),
    .instr_thread (instr_thread),
    .instr        (instr),
    .instr_ack    (instr_ack),
    .wb_vld       (wb_vld),
    .wb_thread    (wb_thread),
    .wb_sel       (wb_sel),
    .wb_data      (wb_data),
    .retire_vld   (retire_vld),
    .retire_flags (retire_flags)
  );

  bind au_top au_chk u_chk
  (
    .CLK        (CLK),
    .RST        (RST),
    .instr_req  (instr_req),
    .instr_ack  (instr_ack),
    .op_vld     (op_vld),
    .op         (op),
    .wb_vld     (wb_vld),
    .retire_vld (retire_vld)
  );

  always #10 CLK = ~CLK;

  // Threads are independent, so any permutation keeps the expected values
  task automatic shuffle_threads();
    int                   j;
    au_core_pkg::thread_t tmp;
    for (int i = 0; i < au_core_pkg::num_threads; i++)
      thread_map[i] = au_core_pkg::thread_t'(i);
    for (int i = au_core_pkg::num_threads - 1; i > 0; i--)
    begin
      j             = int'($unsigned($random(seed)) % (i + 1));
      tmp           = thread_map[i];
      thread_map[i] = thread_map[j];
      thread_map[j] = tmp;
    end
  endtask

  // Full four-phase exchange, returns at a falling edge
  task automatic send_word(input au_core_pkg::thread_t thr, input au_isa_pkg::instr_t word);
    int cnt;
    @(posedge CLK);
    instr_thread <= thr;
    instr        <= word;
    instr_req    <= 1'b1;
    cnt = 0;
    do
    begin
      @(negedge CLK);
      cnt++;
    end
    while (!instr_ack && cnt < timeout_cycles);
    if (!instr_ack)
    begin
      timeouts++;
      $display("Timeout: instr_ack did not rise for thread %0d", thr);
    end
    @(posedge CLK);
    instr_req <= 1'b0;
    cnt = 0;
    do
    begin
      @(negedge CLK);
      cnt++;
    end
    while (instr_ack && cnt < timeout_cycles);
    if (instr_ack)
    begin
      timeouts++;
      $display("Timeout: instr_ack stayed high after instr_req dropped");
    end
  endtask

  // Retirement may already be showing when the handshake ends
  task automatic wait_retire();
    int cnt;
    cnt = 0;
    while (!retire_vld && cnt < timeout_cycles)
    begin
      @(negedge CLK);
      cnt++;
    end
  endtask

  task automatic check_retire(
    input int                    line_no,
    input logic                  exp_wr,
    input au_core_pkg::thread_t  exp_thread,
    input au_core_pkg::reg_sel_t exp_sel,
    input au_core_pkg::word_t    exp_data,
    input au_core_pkg::flags_t   exp_flags
  );
    if (!retire_vld)
    begin
      timeouts++;
      $display("Timeout: no retirement for the op on data line %0d", line_no);
    end
    else
    begin
      checks++;
      if (wb_vld !== exp_wr)
      begin
        errors++;
        $display("FAIL wb_vld: got 0x%h, expected 0x%h (line %0d)", wb_vld, exp_wr, line_no);
      end
      if (exp_wr && wb_thread !== exp_thread)
      begin
        errors++;
        $display("FAIL wb_thread: got 0x%h, expected 0x%h (line %0d)", wb_thread, exp_thread,
                 line_no);
      end
      if (exp_wr && wb_sel !== exp_sel)
      begin
        errors++;
        $display("FAIL wb_sel: got 0x%h, expected 0x%h (line %0d)", wb_sel, exp_sel, line_no);
      end
      if (exp_wr && wb_data !== exp_data)
      begin
        errors++;
        $display("FAIL wb_data: got 0x%h, expected 0x%h (line %0d)", wb_data, exp_data, line_no);
      end
      if (retire_flags !== exp_flags)
      begin
        errors++;
        $display("FAIL retire_flags: got 0x%h, expected 0x%h (line %0d)", retire_flags,
                 exp_flags, line_no);
      end
    end
  endtask

  initial
  begin
    int                   fd;
    int                   rc;
    int                   n;
    int                   line_no;
    string                line;
    int                   f_thread;
    int                   f_prefix;
    logic [27:0]          f_payload;
    int                   f_wr;
    int                   f_sel;
    logic [31:0]          f_data;
    logic [7:0]           f_flags;
    au_core_pkg::thread_t thr;
    au_isa_pkg::instr_t   word;
    CLK          = 1'b0;
    RST          <= 1'b1;
    instr_req    <= 1'b0;
    instr_thread <= '0;
    instr        <= '0;
    errors       = 0;
    timeouts     = 0;
    checks       = 0;
    seed         = 32'h2621;
    shuffle_threads();
    repeat (10) @(posedge CLK);
    RST <= 1'b0;
    fd = $fopen("tests/au_testdata.txt", "r");
    if (fd == 0)
    begin
      errors++;
      $display("Could not open tests/au_testdata.txt");
    end
    else
    begin
      line_no = 0;
      while (!$feof(fd))
      begin
        rc = $fgets(line, fd);
        line_no++;
        // Comment and blank lines fail to scan and are skipped
        n = $sscanf(line, "%d %d %h %d %d %h %h", f_thread, f_prefix, f_payload, f_wr, f_sel,
                    f_data, f_flags);
        if (rc > 0 && n == 7)
        begin
          thr = thread_map[f_thread[1:0]];
          if (f_prefix != 0)
            word = {1'b1, f_payload};
          else
            word = {14'd0, f_payload[14:0]};
          send_word(thr, word);
          if (f_prefix == 0)
          begin
            wait_retire();
            check_retire(line_no, f_wr[0], thr, f_sel[2:0], f_data, f_flags);
          end
        end
      end
      $fclose(fd);
      if (checks == 0)
      begin
        errors++;
        $display("No operations were read from the data file");
      end
    end
    $display("Retirements checked: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule

//--- tests/au_testdata.txt
# thread prefix payload(hex) exp_wr exp_reg exp_data(hex) exp_flags(hex)
# payload is a 28-bit prefix when prefix is 1, else the 15-bit op word; expectations unused for prefixes
0 0 0653 1 3 00000000 01
3 0 07F5 1 5 00000000 01
0 0 3029 1 1 00000005 00
0 0 3062 1 2 0000000C 00
0 0 0053 1 3 0000000D 00
0 0 0254 1 4 00000009 00
0 0 0A55 1 5 00000004 00
0 0 0656 1 6 00000011 00
0 0 0857 1 7 FFFFFFF9 0A
1 0 3FF8 1 0 FFFFFFFF 02
1 0 3801 1 1 FFFFFF00 02
2 1 1234567 0 0 00000000 00
3 1 ABCDEF0 0 0 00000000 00
2 0 3029 1 1 00000005 00
2 0 665A 1 2 12345680 00
3 0 600C 1 4 ABCDEF09 02
1 0 2862 1 2 FFFFF000 02
1 0 2A63 1 3 0FFFFFF0 00
1 0 2C64 1 4 FFFFFFF0 02
1 0 223D 1 5 FFFFFF7F 02
1 0 205E 1 6 FFFFFF08 02
1 0 2ED7 1 7 FFFFFFF0 02
1 0 2F8F 1 7 00000008 00
1 0 2FA7 1 7 00000000 01
0 0 0451 0 1 FFFFFFF9 0A
0 0 0043 1 3 00000005 00
2 0 3FFC 1 4 FFFFFFFF 02
2 0 2B0D 1 5 7FFFFFFF 00
2 0 076E 1 6 FFFFFFFE 06
2 0 0727 1 7 FFFFFFFE 0A
2 0 270F 1 7 00000000 09
2 0 0966 1 6 80000000 0E
2 0 0C02 1 2 FFFFFBAD 02
2 0 7403 1 3 FFFFFBAD 02

//--- vlog.f
hw/au_isa_pkg.sv
hw/au_core_pkg.sv
hw/au_issue.sv
hw/au_regfile.sv
hw/au_exec.sv
hw/au_top.sv
tests/au_chk.sv
tests/au_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the au_tb testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module au_tb -o au_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/au_sim 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -q "SIMULATION PASSED"; then
  exit 0
fi
exit 1
